// ==== compile.f ====
common/cpu_pkg.sv
common/pipe_if.sv
pipeline/fetch_stage.sv
pipeline/decode_stage.sv
pipeline/execute_stage.sv
pipeline/memory_stage.sv
hdl/hazard_unit.sv
hdl/cpu_top.sv
test/tb_cpu.sv

// ==== Makefile ====
# Verilator build and run of the pipelined core testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the core and testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_cpu -Mdir obj_dir -f compile.f
	@out="$$(./obj_dir/Vtb_cpu)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// ==== test/tb_cpu.sv ====
// Testbench for the core: runs directed and random programs and checks every retired write
`timescale 1ns/100ps

module tb_cpu;
   import cpu_pkg::*;

   logic     clk = 1'b0;
   logic     rst_n;
   pc_t      imem_addr;
   instr_t   imem_data;
   logic     wb_valid;
   reg_idx_t wb_reg;
   word_t    wb_data;
   logic     halted;
   logic     err;

   instr_t   prog_mem [256];
   int       prog_len;
   reg_idx_t exp_reg_q [$];
   word_t    exp_val_q [$];
   logic [31:0] seed = 32'h7c90;
   int       errors = 0;
   int       writes_checked = 0;
   int       programs_run = 0;
   logic     timed_out = 1'b0;

   cpu_top i_cpu_top (
      .clk       (clk),
      .rst_n     (rst_n),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .wb_valid  (wb_valid),
      .wb_reg    (wb_reg),
      .wb_data   (wb_data),
      .halted    (halted),
      .err       (err)
   );

   always #50 clk = ~clk;

   // Instruction memory answers in the same cycle
   assign imem_data = prog_mem[imem_addr];

   function automatic int rand_below(input int limit);
      seed = seed * 32'd1664525 + 32'd1013904223;
      return int'(seed[30:16]) % limit;
   endfunction

   function automatic instr_t reg_form(input opcode_t op, input reg_idx_t rd,
                                       input reg_idx_t rs1, input reg_idx_t rs2);
      return {op, rd, rs1, rs2, 3'b000};
   endfunction

   function automatic instr_t imm_form(input opcode_t op, input reg_idx_t rd,
                                       input reg_idx_t rs1, input int imm);
      logic [5:0] imm6;
      imm6 = imm[5:0];
      return {op, rd, rs1, imm6};
   endfunction

   // Instruction-set model, fills the expected write queues
   // Fetch stops one past the HALT address
   function automatic int run_model(output logic exp_err, output pc_t exp_stop_pc);
      word_t    regs [NUM_REGS];
      word_t    dmem [DMEM_WORDS];
      pc_t      pc;
      instr_t   ins;
      opcode_t  op;
      reg_idx_t rd;
      reg_idx_t rs1;
      reg_idx_t rs2;
      word_t    imm;
      word_t    addr;
      word_t    val;
      logic     wr;
      logic     done;
      int       steps;
      for (int i = 0; i < NUM_REGS; i++) begin
         regs[i] = '0;
      end
      for (int i = 0; i < DMEM_WORDS; i++) begin
         dmem[i] = '0;
      end
      exp_reg_q.delete();
      exp_val_q.delete();
      exp_err = 1'b0;
      exp_stop_pc = '0;
      pc = '0;
      done = 1'b0;
      steps = 0;
      while (!done && steps < 512) begin
         ins  = prog_mem[pc];
         op   = ins[15:12];
         rd   = ins[11:9];
         rs1  = ins[8:6];
         rs2  = ins[5:3];
         imm  = {{10{ins[5]}}, ins[5:0]};
         addr = regs[rs1] + imm;
         case (op)
            OP_ADD:  val = regs[rs1] + regs[rs2];
            OP_SUB:  val = regs[rs1] - regs[rs2];
            OP_AND:  val = regs[rs1] & regs[rs2];
            OP_XOR:  val = regs[rs1] ^ regs[rs2];
            OP_ADDI: val = addr;
            OP_LD:   val = dmem[addr[7:0]];
            default: val = '0;
         endcase
         wr = op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_LD};
         pc = pc + 8'd1;
         if (wr) begin
            regs[rd] = val;
            exp_reg_q.push_back(rd);
            exp_val_q.push_back(val);
         end else if (op == OP_ST) begin
            dmem[addr[7:0]] = regs[rd];
         end else if (op == OP_BEQZ) begin
            if (regs[rs1] == '0) begin
               pc = pc + imm[7:0];
            end
         end else if (op == OP_HALT) begin
            exp_stop_pc = pc;
            done = 1'b1;
         end else begin
            exp_err = 1'b1;
         end
         steps++;
      end
      return exp_reg_q.size();
   endfunction

   task automatic check_reg(input reg_idx_t got, input reg_idx_t want);
      if (got !== want) begin
         $display("[ERROR] %0t: write to r%0d, expected r%0d", $time, got, want);
         errors++;
      end
   endtask

   task automatic check_word(input word_t got, input word_t want);
      if (got !== want) begin
         $display("[ERROR] %0t: write data %h, expected %h", $time, got, want);
         errors++;
      end
   endtask

   task automatic check_pc(input pc_t got, input pc_t want);
      if (got !== want) begin
         $display("[ERROR] %0t: fetch address %h after halt, expected %h", $time, got, want);
         errors++;
      end
   endtask

   task automatic check_flag(input logic got, input logic want, input string what);
      if (got !== want) begin
         $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, want);
         errors++;
      end
   endtask

   // One expected entry per retirement
   always @(posedge clk) begin
      if (rst_n && wb_valid) begin
         if (halted) begin
            $display("Register write to r%0d retired after halt at %0t", wb_reg, $time);
            errors++;
         end else if (exp_reg_q.size() == 0) begin
            $display("Unexpected register write to r%0d at %0t", wb_reg, $time);
            errors++;
         end else begin
            check_reg(wb_reg, exp_reg_q.pop_front());
            check_word(wb_data, exp_val_q.pop_front());
            writes_checked++;
         end
      end
   end

   task automatic clear_program();
      prog_len = 0;
      for (int i = 0; i < 256; i++) begin
         prog_mem[i] = {OP_HALT, 12'h000};
      end
   endtask

   task automatic append_instr(input instr_t ins);
      prog_mem[prog_len] = ins;
      prog_len++;
   endtask

   // r7 is never written and serves as a zero base
   task automatic make_random_program();
      int       n;
      int       kind;
      int       off;
      opcode_t  op;
      reg_idx_t rd;
      reg_idx_t rs1;
      reg_idx_t rs2;
      clear_program();
      n = 24 + rand_below(40);
      for (int a = 0; a < 4; a++) begin
         append_instr(imm_form(OP_ST, reg_idx_t'(a), 3'd7, a));
      end
      for (int i = 4; i < n - 1; i++) begin
         kind = rand_below(9);
         rd   = reg_idx_t'(rand_below(7));
         rs1  = reg_idx_t'(rand_below(8));
         rs2  = reg_idx_t'(rand_below(8));
         case (kind)
            0: op = OP_ADD;
            1: op = OP_SUB;
            2: op = OP_AND;
            3: op = OP_XOR;
            4, 5: op = OP_ADDI;
            6: op = OP_LD;
            7: op = OP_ST;
            default: op = OP_BEQZ;
         endcase
         if (kind < 4) begin
            append_instr(reg_form(op, rd, rs1, rs2));
         end else if (op == OP_ADDI) begin
            append_instr(imm_form(op, rd, rs1, rand_below(64) - 32));
         end else if (op == OP_BEQZ) begin
            // Forward only, never past the closing HALT
            off = rand_below(4);
            if (i + 1 + off > n - 1) begin
               off = n - 2 - i;
            end
            append_instr(imm_form(op, 3'd0, rs1, off));
         end else begin
            append_instr(imm_form(op, rd, 3'd7, rand_below(4)));
         end
      end
      append_instr({OP_HALT, 12'h000});
   endtask

   task automatic run_program(input string name);
      int   limit;
      int   cycles;
      int   exp_writes;
      logic exp_err;
      pc_t  exp_stop_pc;
      if (!timed_out) begin
         @(posedge clk);
         rst_n <= 1'b0;
         exp_writes = run_model(exp_err, exp_stop_pc);
         limit = 20 * prog_len;
         repeat (16) @(posedge clk);
         rst_n <= 1'b1;
         cycles = 0;
         while (!halted && cycles < limit) begin
            @(posedge clk);
            cycles++;
         end
         if (!halted) begin
            $display("Program %s did not halt within %0d cycles", name, limit);
            errors++;
            timed_out = 1'b1;
         end else begin
            // Quiet window after halt
            repeat (6) begin
               @(posedge clk);
               check_flag(halted, 1'b1, "halted");
               check_pc(imem_addr, exp_stop_pc);
            end
            @(negedge clk);
            check_flag(err, exp_err, "err");
            if (exp_reg_q.size() != 0) begin
               $display("Program %s ended with %0d of %0d expected writes missing",
                        name, exp_reg_q.size(), exp_writes);
               errors++;
            end
         end
         programs_run++;
      end
   endtask

   initial begin
      rst_n = 1'b0;

      // Back-to-back ALU dependencies
      clear_program();
      append_instr(imm_form(OP_ADDI, 3'd1, 3'd7, 5));
      append_instr(imm_form(OP_ADDI, 3'd2, 3'd1, -3));
      append_instr(reg_form(OP_ADD, 3'd3, 3'd1, 3'd2));
      append_instr(reg_form(OP_SUB, 3'd4, 3'd3, 3'd1));
      append_instr(reg_form(OP_XOR, 3'd5, 3'd4, 3'd3));
      append_instr(reg_form(OP_AND, 3'd6, 3'd5, 3'd3));
      append_instr(imm_form(OP_ADDI, 3'd1, 3'd6, 31));
      append_instr(reg_form(OP_SUB, 3'd2, 3'd7, 3'd1));
      append_instr({OP_HALT, 12'h000});
      run_program("alu_forwarding");

      // Store then load, load-use stalls
      clear_program();
      append_instr(imm_form(OP_ADDI, 3'd1, 3'd7, 12));
      append_instr(imm_form(OP_ADDI, 3'd2, 3'd7, -7));
      append_instr(imm_form(OP_ST, 3'd2, 3'd1, 3));
      append_instr(imm_form(OP_LD, 3'd3, 3'd1, 3));
      append_instr(reg_form(OP_ADD, 3'd4, 3'd3, 3'd1));
      append_instr(imm_form(OP_LD, 3'd5, 3'd7, 15));
      append_instr(reg_form(OP_SUB, 3'd6, 3'd1, 3'd5));
      append_instr(imm_form(OP_ST, 3'd6, 3'd7, 4));
      append_instr(imm_form(OP_LD, 3'd1, 3'd7, 4));
      append_instr(reg_form(OP_XOR, 3'd2, 3'd1, 3'd4));
      append_instr({OP_HALT, 12'h000});
      run_program("load_store");

      // Taken and not-taken branches
      clear_program();
      append_instr(imm_form(OP_ADDI, 3'd1, 3'd7, 4));
      append_instr(imm_form(OP_BEQZ, 3'd0, 3'd7, 2));
      append_instr(imm_form(OP_ADDI, 3'd2, 3'd7, 9));
      append_instr(imm_form(OP_ADDI, 3'd3, 3'd7, 9));
      append_instr(imm_form(OP_BEQZ, 3'd0, 3'd1, 1));
      append_instr(imm_form(OP_ADDI, 3'd4, 3'd1, 1));
      append_instr(reg_form(OP_SUB, 3'd5, 3'd1, 3'd1));
      append_instr(imm_form(OP_BEQZ, 3'd0, 3'd5, 1));
      append_instr(imm_form(OP_ADDI, 3'd6, 3'd7, 7));
      append_instr(imm_form(OP_ADDI, 3'd6, 3'd7, 3));
      append_instr({OP_HALT, 12'h000});
      run_program("branches");

      // Nothing after HALT may retire
      clear_program();
      append_instr(imm_form(OP_ADDI, 3'd1, 3'd7, 1));
      append_instr({OP_HALT, 12'h000});
      append_instr(imm_form(OP_ADDI, 3'd2, 3'd7, 2));
      append_instr(imm_form(OP_ADDI, 3'd3, 3'd7, 3));
      run_program("halt");

      // Undefined opcode sets the sticky flag
      clear_program();
      append_instr(imm_form(OP_ADDI, 3'd1, 3'd7, 2));
      append_instr(16'h9000);
      append_instr(imm_form(OP_ADDI, 3'd2, 3'd1, 3));
      append_instr({OP_HALT, 12'h000});
      run_program("undefined_opcode");

      for (int p = 0; p < 6; p++) begin
         make_random_program();
         run_program($sformatf("random_%0d", p));
      end

      $display("Checked %0d register writes in %0d programs, %0d errors",
               writes_checked, programs_run, errors);
      if (errors == 0 && !timed_out) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== hdl/cpu_top.sv ====
// Top level of the five-stage core: stages, hazard unit, instruction port and retire port
`timescale 1ns/100ps

module cpu_top (
   input  logic              clk,
   input  logic              rst_n,
   output cpu_pkg::pc_t      imem_addr,
   input  cpu_pkg::instr_t   imem_data,
   output logic              wb_valid,
   output cpu_pkg::reg_idx_t wb_reg,
   output cpu_pkg::word_t    wb_data,
   output logic              halted,
   output logic              err
);
   import cpu_pkg::*;

   logic   fd_valid;
   pc_t    fd_pc;
   instr_t fd_instr;
   logic   branch_taken;
   pc_t    branch_target;
   logic   halt_seen;

   id_ex_if  i_id_ex ();
   ex_mem_if i_ex_mem ();
   hazard_if i_hazard ();

   fetch_stage i_fetch_stage (
      .clk           (clk),
      .rst_n         (rst_n),
      .stall         (i_hazard.stall),
      .branch_taken  (branch_taken),
      .branch_target (branch_target),
      .halt_seen     (halt_seen),
      .imem_addr     (imem_addr),
      .imem_data     (imem_data),
      .fd_valid      (fd_valid),
      .fd_pc         (fd_pc),
      .fd_instr      (fd_instr)
   );

   // Taken branch kills the instruction in decode
   decode_stage i_decode_stage (
      .clk       (clk),
      .rst_n     (rst_n),
      .fd_valid  (fd_valid),
      .fd_pc     (fd_pc),
      .fd_instr  (fd_instr),
      .flush     (branch_taken),
      .hz        (i_hazard.decode),
      .de        (i_id_ex.source),
      .halt_seen (halt_seen),
      .err       (err)
   );

   execute_stage i_execute_stage (
      .clk           (clk),
      .rst_n         (rst_n),
      .de            (i_id_ex.sink),
      .hz            (i_hazard.execute),
      .branch_taken  (branch_taken),
      .branch_target (branch_target),
      .em            (i_ex_mem.source)
   );

   memory_stage i_memory_stage (
      .clk      (clk),
      .rst_n    (rst_n),
      .em       (i_ex_mem.sink),
      .hz       (i_hazard.memory),
      .wb_valid (wb_valid),
      .wb_reg   (wb_reg),
      .wb_data  (wb_data),
      .halted   (halted)
   );

   hazard_unit i_hazard_unit (
      .hz (i_hazard.unit),
      .de (i_id_ex.monitor),
      .em (i_ex_mem.monitor)
   );

   // A load in memory never has a reader of its rd right behind it in execute
   a_no_load_forward: assert property (@(posedge clk) disable iff (!rst_n)
      (i_ex_mem.valid && i_ex_mem.is_load && i_id_ex.valid && !i_id_ex.is_halt) |->
         (i_id_ex.rs1 != i_ex_mem.rd &&
          (i_id_ex.rs2 != i_ex_mem.rd || i_id_ex.is_branch ||
           (i_id_ex.use_imm && !i_id_ex.is_store))));

endmodule

// ==== hdl/hazard_unit.sv ====
// Load-use stall detection and operand forward selects, watching the pipeline registers
`timescale 1ns/100ps

module hazard_unit (
   hazard_if.unit    hz,
   id_ex_if.monitor  de,
   ex_mem_if.monitor em
);
   import cpu_pkg::*;

   logic load_in_ex;
   logic mem_fwd_ok;

   function automatic fwd_sel_t select_source(input reg_idx_t src, input logic mem_ok,
                                              input reg_idx_t mem_rd, input logic wb_we,
                                              input reg_idx_t wb_rd);
      fwd_sel_t sel;
      if (mem_ok && mem_rd == src) begin
         sel = FWD_MEM;
      end else if (wb_we && wb_rd == src) begin
         sel = FWD_WB;
      end else begin
         sel = FWD_NONE;
      end
      return sel;
   endfunction

   // Load result not ready until writeback
   assign load_in_ex = de.valid & de.is_load & de.reg_write;

   assign hz.stall = load_in_ex &
                     ((hz.dec_use_a && hz.dec_rs1 == de.rd) ||
                      (hz.dec_use_b && hz.dec_rs2 == de.rd));

   assign mem_fwd_ok = em.valid & em.reg_write & ~em.is_load;

   assign hz.fwd_a = select_source(de.rs1, mem_fwd_ok, em.rd, hz.wb_we, hz.wb_rd);
   assign hz.fwd_b = select_source(de.rs2, mem_fwd_ok, em.rd, hz.wb_we, hz.wb_rd);

endmodule

// ==== pipeline/memory_stage.sv ====
// Data RAM, memory/writeback register and the retire outputs
`timescale 1ns/100ps

module memory_stage (
   input  logic             clk,
   input  logic             rst_n,
   ex_mem_if.sink           em,
   hazard_if.memory         hz,
   output logic             wb_valid,
   output cpu_pkg::reg_idx_t wb_reg,
   output cpu_pkg::word_t   wb_data,
   output logic             halted
);
   import cpu_pkg::*;

   word_t      dmem [DMEM_WORDS];
   dmem_addr_t addr;
   word_t      rd_data;

   // Low bits of the ALU result address the RAM
   assign addr    = dmem_addr_t'(em.result);
   assign rd_data = dmem[addr];

   always_ff @(posedge clk) begin
      if (em.valid && em.is_store) begin
         dmem[addr] <= em.store_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_valid <= 1'b0;
         halted   <= 1'b0;
      end else begin
         wb_valid <= em.valid & em.reg_write;
         // Sticky until reset
         halted   <= halted | (em.valid & em.is_halt);
      end
   end

   always_ff @(posedge clk) begin
      wb_reg  <= em.rd;
      wb_data <= em.is_load ? rd_data : em.result;
   end

   assign hz.wb_we   = wb_valid;
   assign hz.wb_rd   = wb_reg;
   assign hz.wb_data = wb_data;

endmodule

// ==== pipeline/execute_stage.sv ====
// Operand forwarding, ALU, branch resolution and the execute/memory register
`timescale 1ns/100ps

module execute_stage (
   input  logic         clk,
   input  logic         rst_n,
   id_ex_if.sink        de,
   hazard_if.execute    hz,
   output logic         branch_taken,
   output cpu_pkg::pc_t branch_target,
   ex_mem_if.source     em
);
   import cpu_pkg::*;

   word_t op_a;
   word_t op_b;
   word_t alu_in_b;
   word_t alu_res;

   function automatic word_t pick_operand(input fwd_sel_t sel, input word_t reg_val,
                                          input word_t mem_val, input word_t wb_val);
      word_t val;
      case (sel)
         FWD_MEM: val = mem_val;
         FWD_WB:  val = wb_val;
         default: val = reg_val;
      endcase
      return val;
   endfunction

   assign op_a = pick_operand(hz.fwd_a, de.rs1_val, em.result, hz.wb_data);
   assign op_b = pick_operand(hz.fwd_b, de.rs2_val, em.result, hz.wb_data);

   // Immediate forms compute base plus offset
   assign alu_in_b = de.use_imm ? de.imm : op_b;

   always_comb begin
      case (de.alu_op)
         ALU_SUB: alu_res = op_a - alu_in_b;
         ALU_AND: alu_res = op_a & alu_in_b;
         ALU_XOR: alu_res = op_a ^ alu_in_b;
         default: alu_res = op_a + alu_in_b;
      endcase
   end

   // BEQZ tests the forwarded first operand
   assign branch_taken  = de.valid & de.is_branch & (op_a == '0);
   assign branch_target = de.pc + pc_t'(1) + pc_t'(de.imm);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         em.valid     <= 1'b0;
         em.is_load   <= 1'b0;
         em.is_store  <= 1'b0;
         em.reg_write <= 1'b0;
         em.is_halt   <= 1'b0;
      end else begin
         em.valid     <= de.valid;
         em.is_load   <= de.is_load;
         em.is_store  <= de.is_store;
         em.reg_write <= de.reg_write;
         em.is_halt   <= de.is_halt;
      end
   end

   // Store data is the forwarded rd value
   always_ff @(posedge clk) begin
      em.result     <= alu_res;
      em.store_data <= op_b;
      em.rd         <= de.rd;
   end

endmodule

// ==== pipeline/decode_stage.sv ====
// Register file with write bypass, instruction decode, error flag and decode/execute register
`timescale 1ns/100ps

module decode_stage (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            fd_valid,
   input  cpu_pkg::pc_t    fd_pc,
   input  cpu_pkg::instr_t fd_instr,
   input  logic            flush,
   hazard_if.decode        hz,
   id_ex_if.source         de,
   output logic            halt_seen,
   output logic            err
);
   import cpu_pkg::*;

   word_t    regs [NUM_REGS];
   opcode_t  opcode;
   reg_idx_t rd;
   reg_idx_t rs1;
   reg_idx_t rs2;
   word_t    rs1_val;
   word_t    rs2_val;
   word_t    imm_ext;
   alu_op_t  alu_op;
   logic     use_a, use_b, use_imm, src_b_rd;
   logic     is_load, is_store, is_branch, reg_write, is_halt, illegal;
   logic     live;
   logic     bubble;
   logic     halt_q;

   assign opcode  = fd_instr[OPC_HI:OPC_LO];
   assign rd      = fd_instr[RD_HI:RD_LO];
   assign rs1     = fd_instr[RS1_HI:RS1_LO];
   assign imm_ext = {{(WORD_W-IMM_W){fd_instr[IMM_HI]}}, fd_instr[IMM_HI:IMM_LO]};

   // ST and BEQZ read rd on the second port
   assign rs2 = src_b_rd ? rd : fd_instr[RS2_HI:RS2_LO];

   always_comb begin
      alu_op    = ALU_ADD;
      use_a     = 1'b0;
      use_b     = 1'b0;
      use_imm   = 1'b0;
      src_b_rd  = 1'b0;
      is_load   = 1'b0;
      is_store  = 1'b0;
      is_branch = 1'b0;
      reg_write = 1'b0;
      is_halt   = 1'b0;
      illegal   = 1'b0;
      case (opcode)
         OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
            alu_op    = alu_op_t'(opcode);
            use_a     = 1'b1;
            use_b     = 1'b1;
            reg_write = 1'b1;
         end
         OP_ADDI: begin
            use_a     = 1'b1;
            use_imm   = 1'b1;
            reg_write = 1'b1;
         end
         OP_LD: begin
            use_a     = 1'b1;
            use_imm   = 1'b1;
            is_load   = 1'b1;
            reg_write = 1'b1;
         end
         OP_ST: begin
            use_a    = 1'b1;
            use_b    = 1'b1;
            use_imm  = 1'b1;
            src_b_rd = 1'b1;
            is_store = 1'b1;
         end
         OP_BEQZ: begin
            use_a     = 1'b1;
            src_b_rd  = 1'b1;
            is_branch = 1'b1;
         end
         OP_HALT: is_halt = 1'b1;
         default: illegal = 1'b1;
      endcase
   end

   // Register file, writeback wins over the stored value
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (hz.wb_we) begin
         regs[hz.wb_rd] <= hz.wb_data;
      end
   end

   assign rs1_val = (hz.wb_we && hz.wb_rd == rs1) ? hz.wb_data : regs[rs1];
   assign rs2_val = (hz.wb_we && hz.wb_rd == rs2) ? hz.wb_data : regs[rs2];

   assign hz.dec_rs1   = rs1;
   assign hz.dec_rs2   = rs2;
   assign hz.dec_use_a = fd_valid & use_a;
   assign hz.dec_use_b = fd_valid & use_b;

   // Instruction is on the architectural path
   assign live      = fd_valid & ~flush;
   assign bubble    = ~live | hz.stall | illegal;
   assign halt_seen = halt_q | (live & is_halt);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         halt_q       <= 1'b0;
         err          <= 1'b0;
         de.valid     <= 1'b0;
         de.use_imm   <= 1'b0;
         de.is_load   <= 1'b0;
         de.is_store  <= 1'b0;
         de.is_branch <= 1'b0;
         de.reg_write <= 1'b0;
         de.is_halt   <= 1'b0;
      end else begin
         halt_q       <= halt_seen;
         err          <= err | (live & illegal);
         de.valid     <= ~bubble;
         de.use_imm   <= ~bubble & use_imm;
         de.is_load   <= ~bubble & is_load;
         de.is_store  <= ~bubble & is_store;
         de.is_branch <= ~bubble & is_branch;
         de.reg_write <= ~bubble & reg_write;
         de.is_halt   <= ~bubble & is_halt;
      end
   end

   always_ff @(posedge clk) begin
      de.pc      <= fd_pc;
      de.rs1_val <= rs1_val;
      de.rs2_val <= rs2_val;
      de.rs1     <= rs1;
      de.rs2     <= rs2;
      de.rd      <= rd;
      de.imm     <= imm_ext;
      de.alu_op  <= alu_op;
   end

endmodule

// ==== pipeline/fetch_stage.sv ====
// Program counter and fetch/decode register, fed by the external instruction read port
`timescale 1ns/100ps

module fetch_stage (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            stall,
   input  logic            branch_taken,
   input  cpu_pkg::pc_t    branch_target,
   input  logic            halt_seen,
   output cpu_pkg::pc_t    imem_addr,
   input  cpu_pkg::instr_t imem_data,
   output logic            fd_valid,
   output cpu_pkg::pc_t    fd_pc,
   output cpu_pkg::instr_t fd_instr
);
   import cpu_pkg::*;

   pc_t pc;

   assign imem_addr = pc;

   // Redirect beats stall, stall beats halt
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc       <= '0;
         fd_valid <= 1'b0;
      end else if (branch_taken) begin
         pc       <= branch_target;
         fd_valid <= 1'b0;
      end else if (!stall) begin
         if (halt_seen) begin
            fd_valid <= 1'b0;
         end else begin
            pc       <= pc + pc_t'(1);
            fd_valid <= 1'b1;
         end
      end
   end

   // Instruction and its address, no reset needed
   always_ff @(posedge clk) begin
      if (!stall && !branch_taken) begin
         fd_pc    <= pc;
         fd_instr <= imem_data;
      end
   end

   // A load in execute and a branch in execute cannot coexist
   a_no_stall_on_branch: assert property (@(posedge clk) disable iff (!rst_n)
      !(stall && branch_taken && fd_valid));

endmodule

// ==== common/pipe_if.sv ====
// Pipeline register bundles and the hazard bus that tie the core stages to the hazard unit
`timescale 1ns/100ps

interface id_ex_if;
   import cpu_pkg::*;

   logic     valid;
   pc_t      pc;
   word_t    rs1_val;
   word_t    rs2_val;
   reg_idx_t rs1;
   reg_idx_t rs2;
   reg_idx_t rd;
   word_t    imm;
   alu_op_t  alu_op;
   logic     use_imm;
   logic     is_load;
   logic     is_store;
   logic     is_branch;
   logic     reg_write;
   logic     is_halt;

   modport source (output valid, pc, rs1_val, rs2_val, rs1, rs2, rd, imm, alu_op,
                   use_imm, is_load, is_store, is_branch, reg_write, is_halt);
   modport sink (input valid, pc, rs1_val, rs2_val, rs1, rs2, rd, imm, alu_op,
                 use_imm, is_load, is_store, is_branch, reg_write, is_halt);
   modport monitor (input valid, rs1, rs2, rd, is_load, reg_write);
endinterface

interface ex_mem_if;
   import cpu_pkg::*;

   logic     valid;
   word_t    result;
   word_t    store_data;
   reg_idx_t rd;
   logic     is_load;
   logic     is_store;
   logic     reg_write;
   logic     is_halt;

   modport source (output valid, result, store_data, rd, is_load, is_store, reg_write, is_halt);
   modport sink (input valid, result, store_data, rd, is_load, is_store, reg_write, is_halt);
   modport monitor (input valid, rd, is_load, reg_write);
endinterface

interface hazard_if;
   import cpu_pkg::*;

   // Decode side sources
   reg_idx_t dec_rs1;
   reg_idx_t dec_rs2;
   logic     dec_use_a;
   logic     dec_use_b;
   // Writeback port
   reg_idx_t wb_rd;
   logic     wb_we;
   word_t    wb_data;
   // Hazard unit results
   logic     stall;
   fwd_sel_t fwd_a;
   fwd_sel_t fwd_b;

   modport decode (output dec_rs1, dec_rs2, dec_use_a, dec_use_b,
                   input stall, wb_rd, wb_we, wb_data);
   modport execute (input fwd_a, fwd_b, wb_data);
   modport memory (output wb_rd, wb_we, wb_data);
   modport unit (input dec_rs1, dec_rs2, dec_use_a, dec_use_b, wb_rd, wb_we,
                 output stall, fwd_a, fwd_b);
endinterface

// ==== common/cpu_pkg.sv ====
// Types, instruction field positions, opcodes and select codes shared by every stage of the core
package cpu_pkg;

   localparam int WORD_W     = 16;
   localparam int NUM_REGS   = 8;
   localparam int DMEM_WORDS = 256;

   typedef logic [WORD_W-1:0]             word_t;
   typedef logic [WORD_W-1:0]             instr_t;
   typedef logic [$clog2(NUM_REGS)-1:0]   reg_idx_t;
   typedef logic [7:0]                    pc_t;
   typedef logic [$clog2(DMEM_WORDS)-1:0] dmem_addr_t;
   typedef logic [3:0]                    opcode_t;
   typedef logic [1:0]                    alu_op_t;
   typedef logic [1:0]                    fwd_sel_t;

   // Instruction layout
   localparam int OPC_HI = 15;
   localparam int OPC_LO = 12;
   localparam int RD_HI  = 11;
   localparam int RD_LO  = 9;
   localparam int RS1_HI = 8;
   localparam int RS1_LO = 6;
   localparam int RS2_HI = 5;
   localparam int RS2_LO = 3;
   localparam int IMM_HI = 5;
   localparam int IMM_LO = 0;
   localparam int IMM_W  = IMM_HI - IMM_LO + 1;

   // Opcodes, 8 to 14 are undefined
   localparam opcode_t OP_ADD  = 4'h0;
   localparam opcode_t OP_SUB  = 4'h1;
   localparam opcode_t OP_AND  = 4'h2;
   localparam opcode_t OP_XOR  = 4'h3;
   localparam opcode_t OP_ADDI = 4'h4;
   localparam opcode_t OP_LD   = 4'h5;
   localparam opcode_t OP_ST   = 4'h6;
   localparam opcode_t OP_BEQZ = 4'h7;
   localparam opcode_t OP_HALT = 4'hF;

   localparam alu_op_t ALU_ADD = 2'd0;
   localparam alu_op_t ALU_SUB = 2'd1;
   localparam alu_op_t ALU_AND = 2'd2;
   localparam alu_op_t ALU_XOR = 2'd3;

   // Operand sources in execute
   localparam fwd_sel_t FWD_NONE = 2'd0;
   localparam fwd_sel_t FWD_MEM  = 2'd1;
   localparam fwd_sel_t FWD_WB   = 2'd2;

endpackage
